// ==== Bender.yml ====
package:
  name: uop_sequencer

sources:
  - include_dirs:
      - design
    files:
      - design/arm_isa_pkg.sv
      - design/uop_seq_pkg.sv
      - design/reglist_walker.sv
      - design/uop_encoder.sv
      - design/uop_sequencer_ctrl.sv
      - design/uop_sequencer_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - verification/uop_sequencer_checker.sv
      - verification/uop_sequencer_tb.sv

// ==== design/arm_isa_pkg.sv ====
/*
 * ARM instruction-set types shared by the sequencer.
 * Data-processing opcodes, extended register codes and the AL condition.
 */

package arm_isa_pkg;

        // Data-processing opcodes used by the generated micro-ops.
        typedef enum logic [3:0] {
                SUB = 4'b0010,
                ADD = 4'b0100,
                ORR = 4'b1100,
                MOV = 4'b1101
        } dp_opcode_e;

        // Register codes of five bits.
        // Codes above 15 are internal or user-bank registers.
        typedef enum logic [4:0] {
                ARCH_R0         = 5'd0,
                ARCH_SP         = 5'd13,
                ARCH_LR         = 5'd14,
                ARCH_PC         = 5'd15,
                ARCH_DUMMY_REG0 = 5'd16,
                ARCH_DUMMY_REG1 = 5'd17,
                ARCH_USR2_R8    = 5'd18,
                ARCH_USR2_R9    = 5'd19,
                ARCH_USR2_R10   = 5'd20,
                ARCH_USR2_R11   = 5'd21,
                ARCH_USR2_R12   = 5'd22,
                ARCH_USR2_R13   = 5'd23,
                ARCH_USR2_R14   = 5'd24
        } reg_code_e;

        // Always-execute condition field.
        localparam logic [3:0] COND_AL = 4'b1110;

endpackage

// ==== design/reglist_walker.sv ====
/*
 * Register list walker.
 * Holds the remaining list, picks the lowest set register and
 * gives the byte size of the incoming list.
 */

`timescale 1ns/10ps
`include "uop_config.svh"

module reglist_walker
(
        input  logic                    i_clk,
        input  logic                    i_reset,
        input  logic                    i_flush,
        input  logic                    i_hold,
        input  logic                    i_load_list,
        input  logic                    i_advance,
        input  logic [`REGLIST_W-1:0]   i_list,
        output logic [3:0]              o_index,
        output logic                    o_list_empty,
        output logic [`OFFSET_W-1:0]    o_offset
);

// Remaining registers still to transfer.
logic [`REGLIST_W-1:0]  list_ff;
logic [`REGLIST_W-1:0]  list_nxt;

// Number of set bits in the incoming list, 0 to 16.
logic [4:0]             ones;

////////////////////////////////////////////////////////////////////////////

// Priority encoder.
// Scanning from the top lets the lowest set bit win.
always_comb
begin
        o_index = 4'd0;
        for (int i = `REGLIST_W - 1; i >= 0; i--)
        begin
                if (list_ff[i])
                begin
                        o_index = 4'(i);
                end
        end
end

always_comb o_list_empty = (list_ff == '0);

// Block transfers move words, so the size is four bytes per register.
always_comb
begin
        ones = 5'd0;
        for (int i = 0; i < `REGLIST_W; i++)
        begin
                ones = ones + {4'd0, i_list[i]};
        end
        o_offset = `OFFSET_W'({ones, 2'b00});
end

////////////////////////////////////////////////////////////////////////////

// Capture a new list, or drop the register just transferred.
always_comb
begin
        list_nxt = list_ff;
        if (i_load_list)
        begin
                list_nxt = i_list;
        end
        else if (i_advance)
        begin
                list_nxt = list_ff & ~(`REGLIST_W'(1) << o_index);
        end
end

// Flush beats hold.
always_ff @(posedge i_clk)
begin
        if (i_reset || i_flush)
        begin
                list_ff <= '0;
        end
        else if (!i_hold)
        begin
                list_ff <= list_nxt;
        end
end

endmodule

// ==== design/uop_config.svh ====
/*
 * Fixed field positions and widths of the micro-op word.
 * The low 32 bits hold an ARM instruction and bits 39:32 extend register fields.
 */

`ifndef UOP_CONFIG_SVH
`define UOP_CONFIG_SVH

// Word widths.
`define INSTR_W         32
`define UOP_W           40
`define REGLIST_W       16
`define OFFSET_W        12

// Destination or source register of a data-processing or memory op.
`define SRCDEST_MSB     15
`define SRCDEST_LSB     12

// Base register, also the first ALU operand.
`define BASE_MSB        19
`define BASE_LSB        16

// Register operand in the low nibble.
`define RM_MSB          3
`define RM_LSB          0

// Fifth bit of each register code.
`define SRCDEST_EXT     32
`define BASE_EXT        33
`define RM_EXT          34

`endif

// ==== design/uop_encoder.sv ====
/*
 * Micro-op encoder.
 * Builds the 40-bit word for the current state from the held
 * instruction: base backup, single transfers, closing op,
 * PC write, the swap steps and plain pass-through.
 */

`timescale 1ns/10ps
`include "uop_config.svh"

module uop_encoder
(
        input  logic [`INSTR_W-1:0]             i_instruction,
        input  uop_seq_pkg::seq_state_e         i_state,
        input  uop_seq_pkg::instr_class_e       i_class,
        input  logic [3:0]                      i_index,
        input  logic                            i_list_empty,
        input  logic [`OFFSET_W-1:0]            i_offset,
        output logic [`UOP_W-1:0]               o_uop
);

import arm_isa_pkg::*;
import uop_seq_pkg::*;

// Fields of the held instruction.
logic [3:0]     cc;
logic           up;
logic           s_bit;
logic           writeback;
logic           load;
logic [3:0]     base;
logic [3:0]     rd;

// User-bank access for S-bit transfers.
logic           user_bank;
logic [4:0]     usr_reg;

always_comb
begin
        cc        = i_instruction[31:28];
        up        = i_instruction[23];
        s_bit     = i_instruction[22];
        writeback = i_instruction[21];
        load      = i_instruction[20];
        base      = i_instruction[`BASE_MSB:`BASE_LSB];
        rd        = i_instruction[`SRCDEST_MSB:`SRCDEST_LSB];
end

// STM with S, or LDM with S and no PC, reaches the user bank.
always_comb user_bank = s_bit && (!load || !i_instruction[ARCH_PC]);
always_comb usr_reg   = 5'(ARCH_USR2_R8) + {1'b0, i_index} - 5'd8;

////////////////////////////////////////////////////////////////////////////

always_comb
begin
        // Pass-through word with clear extension bits.
        o_uop = {8'd0, i_instruction};

        case (i_state)
        IDLE:
        begin
                if (i_class == CLS_BLOCK)
                begin
                        // Back up the base into dummy0.
                        // A decrementing transfer starts at the bottom of the block.
                        if (up)
                        begin
                                o_uop[31:0] = {cc, 2'b00, 1'b0, MOV, 1'b0, 4'd0, 4'd0,
                                               8'd0, base};
                        end
                        else
                        begin
                                o_uop[31:0] = {cc, 2'b00, 1'b1, SUB, 1'b0, base, 4'd0,
                                               i_offset};
                        end
                        {o_uop[`SRCDEST_EXT], o_uop[`SRCDEST_MSB:`SRCDEST_LSB]} =
                                ARCH_DUMMY_REG0;
                end
                else if (i_class == CLS_SWAP)
                begin
                        // LDR dummy0, [Rn].
                        o_uop[31:0] = {cc, 3'b010, 1'b1, 1'b0, i_instruction[22], 1'b0,
                                       1'b1, base, 4'd0, 12'd0};
                        {o_uop[`SRCDEST_EXT], o_uop[`SRCDEST_MSB:`SRCDEST_LSB]} =
                                ARCH_DUMMY_REG0;
                end
        end

        MEMOP:
        begin
                if (i_list_empty)
                begin
                        // Closing op.
                        // Writeback restores or moves the base, else the slot is empty.
                        if (!writeback)
                        begin
                                o_uop = '0;
                        end
                        else if (up)
                        begin
                                o_uop[31:0] = {cc, 2'b00, 1'b0, MOV, 1'b0, 4'd0, base,
                                               8'd0, 4'd0};
                                {o_uop[`RM_EXT], o_uop[`RM_MSB:`RM_LSB]} = ARCH_DUMMY_REG0;
                        end
                        else
                        begin
                                o_uop[31:0] = {cc, 2'b00, 1'b1, SUB, 1'b0, base, base,
                                               i_offset};
                        end
                end
                else
                begin
                        // Single word transfer off dummy0, always incrementing by 4.
                        o_uop[27:26] = 2'b01;
                        o_uop[25]    = 1'b0;
                        // Decrementing modes swap pre and post indexing.
                        o_uop[24]    = up ? i_instruction[24] : ~i_instruction[24];
                        o_uop[23]    = 1'b1;
                        o_uop[22]    = 1'b0;
                        // Post-index writes back anyway.
                        o_uop[21]    = o_uop[24];
                        o_uop[`OFFSET_W-1:0] = `OFFSET_W'(4);
                        o_uop[`SRCDEST_MSB:`SRCDEST_LSB] = i_index;
                        {o_uop[`BASE_EXT], o_uop[`BASE_MSB:`BASE_LSB]} = ARCH_DUMMY_REG0;

                        if (user_bank && i_index >= 4'd8 && i_index != ARCH_PC[3:0])
                        begin
                                {o_uop[`SRCDEST_EXT], o_uop[`SRCDEST_MSB:`SRCDEST_LSB]} =
                                        usr_reg;
                        end
                        else if (load && i_index == ARCH_PC[3:0])
                        begin
                                // PC is parked in dummy1 until WRITE_PC.
                                {o_uop[`SRCDEST_EXT], o_uop[`SRCDEST_MSB:`SRCDEST_LSB]} =
                                        ARCH_DUMMY_REG1;
                        end
                end
        end

        WRITE_PC:
        begin
                // MOV(S) PC, dummy1.
                o_uop[31:0] = {cc, 2'b00, 1'b0, MOV, s_bit, 4'd0, ARCH_PC[3:0], 8'd0,
                               4'd0};
                {o_uop[`RM_EXT], o_uop[`RM_MSB:`RM_LSB]} = ARCH_DUMMY_REG1;
        end

        SWAP1, SWAP3:
        begin
                // STR Rm, [Rn].
                o_uop[31:0] = {cc, 3'b010, 1'b1, 1'b0, i_instruction[22], 1'b0, 1'b0,
                               base, i_instruction[`RM_MSB:`RM_LSB], 12'd0};
        end

        SWAP2:
        begin
                // MOV Rd, dummy0.
                o_uop[31:0] = {cc, 2'b00, 1'b0, MOV, 1'b0, 4'd0, rd, 12'd0};
                {o_uop[`RM_EXT], o_uop[`RM_MSB:`RM_LSB]} = ARCH_DUMMY_REG0;
        end

        default:
        begin
                o_uop = {8'd0, i_instruction};
        end
        endcase
end

endmodule

// ==== design/uop_seq_pkg.sv ====
/*
 * Sequencer types.
 * FSM states and the instruction classes found by the decoder.
 */

package uop_seq_pkg;

        // FSM states.
        typedef enum logic [2:0] {
                IDLE,
                MEMOP,
                WRITE_PC,
                SWAP1,
                SWAP2,
                SWAP3
        } seq_state_e;

        // What the incoming instruction turns into.
        typedef enum logic [1:0] {
                CLS_OTHER,
                CLS_BLOCK,
                CLS_SWAP
        } instr_class_e;

endpackage

// ==== design/uop_sequencer_ctrl.sv ====
/*
 * Sequencer control.
 * Classifies the instruction, runs the FSM and drives stall,
 * valid and the interrupt gating.
 */

`timescale 1ns/10ps
`include "uop_config.svh"

module uop_sequencer_ctrl
(
        input  logic                            i_clk,
        input  logic                            i_reset,
        input  logic                            i_flush,
        input  logic                            i_hold,
        input  logic [`INSTR_W-1:0]             i_instruction,
        input  logic                            i_instruction_valid,
        input  logic                            i_irq,
        input  logic                            i_fiq,
        input  logic                            i_list_empty,
        output uop_seq_pkg::seq_state_e         o_state,
        output uop_seq_pkg::instr_class_e       o_class,
        output logic                            o_load_list,
        output logic                            o_advance,
        output logic                            o_uop_valid,
        output logic                            o_stall,
        output logic                            o_irq,
        output logic                            o_fiq
);

import arm_isa_pkg::*;
import uop_seq_pkg::*;

seq_state_e     state_ff;
seq_state_e     state_nxt;
logic           is_block;
logic           is_swap;
logic           pc_load;

////////////////////////////////////////////////////////////////////////////
// Decode.
////////////////////////////////////////////////////////////////////////////

// LDM or STM.
always_comb is_block = i_instruction_valid && (i_instruction[27:25] == 3'b100);

// SWP or SWPB.
always_comb is_swap = i_instruction_valid &&
                      (i_instruction[27:23] == 5'b00010) &&
                      (i_instruction[21:20] == 2'b00) &&
                      (i_instruction[11:4] == 8'b0000_1001);

// Loading PC needs the extra WRITE_PC step.
always_comb pc_load = i_instruction[20] && i_instruction[ARCH_PC];

always_comb
begin
        if (is_block)
                o_class = CLS_BLOCK;
        else if (is_swap)
                o_class = CLS_SWAP;
        else
                o_class = CLS_OTHER;
end

////////////////////////////////////////////////////////////////////////////
// FSM.
////////////////////////////////////////////////////////////////////////////

always_comb
begin
        state_nxt   = state_ff;
        o_load_list = 1'b0;
        o_advance   = 1'b0;
        o_uop_valid = 1'b1;
        o_stall     = 1'b1;

        case (state_ff)
        IDLE:
        begin
                if (is_block)
                begin
                        o_load_list = 1'b1;
                        state_nxt   = MEMOP;
                end
                else if (is_swap)
                begin
                        state_nxt = SWAP1;
                end
                else
                begin
                        // Transparent.
                        o_uop_valid = i_instruction_valid;
                        o_stall     = 1'b0;
                end
        end

        MEMOP:
        begin
                if (!i_list_empty)
                begin
                        o_advance = 1'b1;
                end
                else if (pc_load)
                begin
                        state_nxt = WRITE_PC;
                end
                else
                begin
                        o_stall   = 1'b0;
                        state_nxt = IDLE;
                end
        end

        SWAP1:  state_nxt = SWAP2;
        SWAP2:  state_nxt = SWAP3;

        // Last op of a sequence releases fetch.
        default:
        begin
                o_stall   = 1'b0;
                state_nxt = IDLE;
        end
        endcase
end

// Interrupts ride only on the first op of a sequence.
always_comb o_irq = (state_ff == IDLE) && i_irq;
always_comb o_fiq = (state_ff == IDLE) && i_fiq;

always_comb o_state = state_ff;

// Flush beats hold.
always_ff @(posedge i_clk)
begin
        if (i_reset || i_flush)
        begin
                state_ff <= IDLE;
        end
        else if (!i_hold)
        begin
                state_ff <= state_nxt;
        end
end

endmodule

// ==== design/uop_sequencer_top.sv ====
/*
 * Micro-op sequencer top level.
 * Connects the control FSM, the register-list walker and the encoder.
 */

`timescale 1ns/10ps
`include "uop_config.svh"

module uop_sequencer_top
(
        input  logic                    i_clk,
        input  logic                    i_reset,
        input  logic [`INSTR_W-1:0]     i_instruction,
        input  logic                    i_instruction_valid,
        input  logic                    i_irq,
        input  logic                    i_fiq,
        input  logic                    i_flush,
        input  logic                    i_hold,
        output logic [`UOP_W-1:0]       o_uop,
        output logic                    o_uop_valid,
        output logic                    o_stall,
        output logic                    o_irq,
        output logic                    o_fiq
);

import uop_seq_pkg::*;

seq_state_e             state;
instr_class_e           instr_class;
logic                   load_list;
logic                   advance;
logic                   list_empty;
logic [3:0]             index;
logic [`OFFSET_W-1:0]   offset;

uop_sequencer_ctrl u_ctrl (
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_flush                (i_flush),
        .i_hold                 (i_hold),
        .i_instruction          (i_instruction),
        .i_instruction_valid    (i_instruction_valid),
        .i_irq                  (i_irq),
        .i_fiq                  (i_fiq),
        .i_list_empty           (list_empty),
        .o_state                (state),
        .o_class                (instr_class),
        .o_load_list            (load_list),
        .o_advance              (advance),
        .o_uop_valid            (o_uop_valid),
        .o_stall                (o_stall),
        .o_irq                  (o_irq),
        .o_fiq                  (o_fiq)
);

// The list sits in the low half of the instruction.
reglist_walker u_walker (
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_flush                (i_flush),
        .i_hold                 (i_hold),
        .i_load_list            (load_list),
        .i_advance              (advance),
        .i_list                 (i_instruction[`REGLIST_W-1:0]),
        .o_index                (index),
        .o_list_empty           (list_empty),
        .o_offset               (offset)
);

uop_encoder u_encoder (
        .i_instruction          (i_instruction),
        .i_state                (state),
        .i_class                (instr_class),
        .i_index                (index),
        .i_list_empty           (list_empty),
        .i_offset               (offset),
        .o_uop                  (o_uop)
);

endmodule

// ==== list.f ====
+incdir+design
design/arm_isa_pkg.sv
design/uop_seq_pkg.sv
design/reglist_walker.sv
design/uop_encoder.sv
design/uop_sequencer_ctrl.sv
design/uop_sequencer_top.sv
verification/uop_sequencer_checker.sv
verification/uop_sequencer_tb.sv

// ==== verification/uop_sequencer_checker.sv ====
/*
 * Assertions for the micro-op sequencer.
 * Stall after flush, interrupt masking and valid during stall.
 */

`timescale 1ns/10ps

module uop_sequencer_checker
(
        input  logic    i_clk,
        input  logic    i_reset,
        input  logic    i_flush,
        input  logic    i_stall,
        input  logic    i_uop_valid,
        input  logic    i_irq
);

// Number of failed assertions so far.
int unsigned fail_count = 0;

// A flush drops the sequence, so fetch is released next cycle.
a_flush_releases_stall: assert property (@(posedge i_clk) disable iff (i_reset)
        $past(i_flush) |-> !i_stall)
else
begin
        $error("o_stall high in the cycle after a flush");
        fail_count++;
end

// IRQ only on the first op of a sequence or on a pass-through.
// A flushed sequence ends without its last op.
a_irq_first_op: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_irq && !$past(i_flush)) |->
        ($rose(i_stall) || (!i_stall && !$past(i_stall))))
else
begin
        $error("o_irq high on a later micro-op of a sequence");
        fail_count++;
end

// Every op of a running sequence is a real micro-op.
a_valid_on_stall: assert property (@(posedge i_clk) disable iff (i_reset)
        i_stall |-> i_uop_valid)
else
begin
        $error("o_uop_valid low while o_stall is high");
        fail_count++;
end

endmodule

// ==== verification/uop_sequencer_tb.sv ====
/*
 * Testbench for the micro-op sequencer.
 * Clock, reset, a table of stimulus and expected micro-ops,
 * the compare task, the timeout and the final verdict.
 */

`timescale 1ns/10ps
`include "uop_config.svh"

module uop_sequencer_tb;

// One table row holds the inputs first and the expected outputs after.
// first marks the op that forwards interrupts.
typedef struct packed
{
        logic [`INSTR_W-1:0]    instr;
        logic                   valid;
        logic                   hold;
        logic                   flush;
        logic [`UOP_W-1:0]      uop;
        logic                   uop_valid;
        logic                   stall;
        logic                   first;
} row_t;

// Instructions under test.
localparam logic [31:0] add_r1 = 32'hE082_1003;   // ADD   R1, R2, R3
localparam logic [31:0] ldm_ia = 32'hE8B4_0026;   // LDMIA R4!, {R1, R2, R5}
localparam logic [31:0] stm_db = 32'hE94D_1200;   // STMDB R13, {R9, R12}^
localparam logic [31:0] ldm_pc = 32'hE8D0_8008;   // LDMIA R0, {R3, PC}^
localparam logic [31:0] swp_r1 = 32'hE103_1092;   // SWP   R1, R2, [R3]
localparam logic [31:0] ldm_ib = 32'hE992_01C0;   // LDMIB R2, {R6, R7, R8}
localparam logic [31:0] orr_r5 = 32'hE386_50FF;   // ORR   R5, R6, #0xFF

logic                   i_clk = 1'b0;
logic                   i_reset;
logic [`INSTR_W-1:0]    i_instruction;
logic                   i_instruction_valid;
logic                   i_irq;
logic                   i_fiq;
logic                   i_flush;
logic                   i_hold;
logic [`UOP_W-1:0]      o_uop;
logic                   o_uop_valid;
logic                   o_stall;
logic                   o_irq;
logic                   o_fiq;

row_t                   rows[$];
int unsigned            cycle_count = 0;
int unsigned            cycle_limit = 0;
integer                 seed = 37;

uop_sequencer_top dut_i (
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_instruction          (i_instruction),
        .i_instruction_valid    (i_instruction_valid),
        .i_irq                  (i_irq),
        .i_fiq                  (i_fiq),
        .i_flush                (i_flush),
        .i_hold                 (i_hold),
        .o_uop                  (o_uop),
        .o_uop_valid            (o_uop_valid),
        .o_stall                (o_stall),
        .o_irq                  (o_irq),
        .o_fiq                  (o_fiq)
);

bind uop_sequencer_top uop_sequencer_checker u_checker (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_flush        (i_flush),
        .i_stall        (o_stall),
        .i_uop_valid    (o_uop_valid),
        .i_irq          (o_irq)
);

// 40 ns clock.
always #20 i_clk = ~i_clk;

//////////////////////////////////////////////////////////////////////////////
// Helpers.
//////////////////////////////////////////////////////////////////////////////

task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "run stopped on error");
endtask

task automatic compare_value(input string name, input logic [`UOP_W-1:0] actual,
                             input logic [`UOP_W-1:0] expected);
        if (actual !== expected)
        begin
                $display("ERR %0t %s got %0h expected %0h", $time, name, actual, expected);
                abort_run("Output value mismatch.");
        end
endtask

task automatic add_row(input logic [31:0] instr, input logic valid, hold, flush,
                       input logic [39:0] uop, input logic uop_valid, stall, first);
        rows.push_back({instr, valid, hold, flush, uop, uop_valid, stall, first});
endtask

// In expected words bit 32 extends Rd, bit 33 Rn and bit 34 Rm.
task automatic build_table();
        // Pass-through with the valid input high and then low.
        add_row(add_r1, 1'b1, 1'b0, 1'b0, 40'h00_E082_1003, 1'b1, 1'b0, 1'b1);
        add_row(add_r1, 1'b0, 1'b0, 1'b0, 40'h00_E082_1003, 1'b0, 1'b0, 1'b1);
        // MOV D0, R4; LDR R1, R2, R5 off D0; MOV R4, D0.
        add_row(ldm_ia, 1'b1, 1'b0, 1'b0, 40'h01_E1A0_0004, 1'b1, 1'b1, 1'b1);
        add_row(ldm_ia, 1'b1, 1'b0, 1'b0, 40'h02_E490_1004, 1'b1, 1'b1, 1'b0);
        add_row(ldm_ia, 1'b1, 1'b0, 1'b0, 40'h02_E490_2004, 1'b1, 1'b1, 1'b0);
        add_row(ldm_ia, 1'b1, 1'b0, 1'b0, 40'h02_E490_5004, 1'b1, 1'b1, 1'b0);
        add_row(ldm_ia, 1'b1, 1'b0, 1'b0, 40'h04_E1A0_4000, 1'b1, 1'b0, 1'b0);
        // SUB D0, R13, #8; STR USR R9 and USR R12; empty closing op.
        add_row(stm_db, 1'b1, 1'b0, 1'b0, 40'h01_E24D_0008, 1'b1, 1'b1, 1'b1);
        add_row(stm_db, 1'b1, 1'b0, 1'b0, 40'h03_E480_3004, 1'b1, 1'b1, 1'b0);
        add_row(stm_db, 1'b1, 1'b0, 1'b0, 40'h03_E480_6004, 1'b1, 1'b1, 1'b0);
        add_row(stm_db, 1'b1, 1'b0, 1'b0, 40'h00_0000_0000, 1'b1, 1'b0, 1'b0);
        // MOV D0, R0; LDR R3; LDR D1; empty closing op; MOVS PC, D1.
        add_row(ldm_pc, 1'b1, 1'b0, 1'b0, 40'h01_E1A0_0000, 1'b1, 1'b1, 1'b1);
        add_row(ldm_pc, 1'b1, 1'b0, 1'b0, 40'h02_E490_3004, 1'b1, 1'b1, 1'b0);
        add_row(ldm_pc, 1'b1, 1'b0, 1'b0, 40'h03_E490_1004, 1'b1, 1'b1, 1'b0);
        add_row(ldm_pc, 1'b1, 1'b0, 1'b0, 40'h00_0000_0000, 1'b1, 1'b1, 1'b0);
        add_row(ldm_pc, 1'b1, 1'b0, 1'b0, 40'h04_E1B0_F001, 1'b1, 1'b0, 1'b0);
        // LDR D0, [R3]; STR R2, [R3]; MOV R1, D0; STR R2, [R3].
        add_row(swp_r1, 1'b1, 1'b0, 1'b0, 40'h01_E513_0000, 1'b1, 1'b1, 1'b1);
        add_row(swp_r1, 1'b1, 1'b0, 1'b0, 40'h00_E503_2000, 1'b1, 1'b1, 1'b0);
        add_row(swp_r1, 1'b1, 1'b0, 1'b0, 40'h04_E1A0_1000, 1'b1, 1'b1, 1'b0);
        add_row(swp_r1, 1'b1, 1'b0, 1'b0, 40'h00_E503_2000, 1'b1, 1'b0, 1'b0);
        // Hold for two edges on the R6 transfer, then flush on R7.
        // R8 is still pending, so the flush cuts a stalled sequence short.
        add_row(ldm_ib, 1'b1, 1'b0, 1'b0, 40'h01_E1A0_0002, 1'b1, 1'b1, 1'b1);
        add_row(ldm_ib, 1'b1, 1'b1, 1'b0, 40'h02_E5B0_6004, 1'b1, 1'b1, 1'b0);
        add_row(ldm_ib, 1'b1, 1'b1, 1'b0, 40'h02_E5B0_6004, 1'b1, 1'b1, 1'b0);
        add_row(ldm_ib, 1'b1, 1'b0, 1'b0, 40'h02_E5B0_6004, 1'b1, 1'b1, 1'b0);
        add_row(ldm_ib, 1'b1, 1'b0, 1'b1, 40'h02_E5B0_7004, 1'b1, 1'b1, 1'b0);
        add_row(orr_r5, 1'b1, 1'b0, 1'b0, 40'h00_E386_50FF, 1'b1, 1'b0, 1'b1);
endtask

//////////////////////////////////////////////////////////////////////////////
// Timeout.
//////////////////////////////////////////////////////////////////////////////

always @(posedge i_clk)
begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit)
        begin
                abort_run("Timeout: the table did not finish in time.");
        end
end

//////////////////////////////////////////////////////////////////////////////
// Stimulus and checks.
//////////////////////////////////////////////////////////////////////////////

initial
begin
        logic [31:0]    rnd;
        logic           irq_v;
        logic           fiq_v;

        $timeformat(-9, 0, " ns", 0);
        i_reset             = 1'b1;
        i_instruction       = '0;
        i_instruction_valid = 1'b0;
        i_irq               = 1'b0;
        i_fiq               = 1'b0;
        i_flush             = 1'b0;
        i_hold              = 1'b0;
        build_table();
        cycle_limit = rows.size() + 20;

        repeat (2) @(posedge i_clk);
        i_reset <= 1'b0;

        foreach (rows[n])
        begin
                @(posedge i_clk);
                rnd   = $random(seed);
                irq_v = rnd[0];
                fiq_v = rnd[1];
                i_instruction       <= rows[n].instr;
                i_instruction_valid <= rows[n].valid;
                i_hold              <= rows[n].hold;
                i_flush             <= rows[n].flush;
                i_irq               <= irq_v;
                i_fiq               <= fiq_v;

                // Outputs settle well before the next edge.
                @(negedge i_clk);
                compare_value("o_uop", o_uop, rows[n].uop);
                compare_value("o_uop_valid", 40'(o_uop_valid), 40'(rows[n].uop_valid));
                compare_value("o_stall", 40'(o_stall), 40'(rows[n].stall));
                compare_value("o_irq", 40'(o_irq), 40'(rows[n].first & irq_v));
                compare_value("o_fiq", 40'(o_fiq), 40'(rows[n].first & fiq_v));
                compare_value("assertion failures", 40'(dut_i.u_checker.fail_count), 40'd0);
        end

        // One more edge so the last row is seen by the assertions.
        @(posedge i_clk);
        @(negedge i_clk);
        if (dut_i.u_checker.fail_count == 0)
        begin
                $display("*** PASSED ***");
                $finish;
        end
        else
        begin
                abort_run("An assertion in the checker failed.");
        end
end

endmodule
